/* hdl/soc_bus_pkg.sv */
// Wishbone bus widths, bus-space tag enum, master request and slave response structs
`default_nettype none

package soc_bus_pkg;

  localparam int ADR_W = 19;  // Word address, byte address bits 19:1
  localparam int DAT_W = 16;
  localparam int SEL_W = DAT_W / 8;

  // Address space tag carried next to the word address
  typedef enum logic [0:0] {
    SPACE_MEM = 1'b0,
    SPACE_IO  = 1'b1
  } bus_space_e;

  // Master side of a classic Wishbone cycle
  typedef struct packed {
    logic [ADR_W-1:0] adr;
    bus_space_e       space;
    logic [DAT_W-1:0] dat;
    logic [SEL_W-1:0] sel;
    logic             we;
    logic             cyc;
    logic             stb;
    logic             tgc;    // Interrupt acknowledge cycle
  } wb_req_t;

  // Slave answer, data is zero while ack is low
  typedef struct packed {
    logic [DAT_W-1:0] dat;
    logic             ack;
  } wb_rsp_t;

endpackage

`default_nettype wire

/* hdl/soc_map_pkg.sv */
// Memory map package: window struct, RAM window table, default slave data and vector prefix
`default_nettype none

package soc_map_pkg;

  // Tag bit on top of the word address
  localparam int WIN_W = soc_bus_pkg::ADR_W + 1;

  typedef struct packed {
    logic [WIN_W-1:0] base;
    logic [WIN_W-1:0] mask;   // Ones mark the bits that must match
  } win_t;

  localparam int NUM_WIN_MAX = 4;

  // Both windows hold 512 words
  localparam win_t RAM_WIN [NUM_WIN_MAX] = '{
    '{base: {soc_bus_pkg::SPACE_MEM, 19'h00000}, mask: 20'hffe00},  // Base RAM, words 0 to 0x1ff
    '{base: {soc_bus_pkg::SPACE_MEM, 19'h5c000}, mask: 20'hffe00},  // Text memory at 0xb8000
    '{base: '1, mask: '1},
    '{base: '1, mask: '1}
  };

  // Read value of unmapped locations
  localparam logic [soc_bus_pkg::DAT_W-1:0] DEFAULT_DATA = 16'hffff;

  // Upper vector bits, the low three carry the interrupt id
  localparam logic [soc_bus_pkg::DAT_W-4:0] INTA_PREFIX = 13'h0001;

endpackage

`default_nettype wire

/* hdl/wb_addr_decoder.sv */
// Wishbone address decoder with window table match, one strobe per RAM window and default strobe
`timescale 1ns/10ps
`default_nettype none

module wb_addr_decoder #(
  parameter int NUM_RAM = 2
) (
  input  logic                 clk,
  input  logic                 rst_lck,
  input  soc_bus_pkg::wb_req_t req_i,
  output logic [NUM_RAM-1:0]   win_stb_o,
  output logic                 def_stb_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [ADR_W:0] tag_adr;  // {space, word address}
  logic           req_act;
  logic           hit;

  assign tag_adr = {req_i.space, req_i.adr};
  assign req_act = req_i.cyc & req_i.stb;

  // First matching window wins and acknowledge cycles never hit
  always_comb begin
    win_stb_o = '0;
    hit       = 1'b0;
    for (int i = 0; i < NUM_RAM; i++) begin
      if (!hit && !req_i.tgc &&
          ((tag_adr & RAM_WIN[i].mask) == (RAM_WIN[i].base & RAM_WIN[i].mask))) begin
        win_stb_o[i] = req_act;
        hit          = 1'b1;
      end
    end
  end

  assign def_stb_o = req_act & !hit;  // Unmapped, I/O or inta

  // Exactly one target per strobe
  a_one_target: assert property (
    @(posedge clk) disable iff (!rst_lck)
    req_act |-> $onehot({win_stb_o, def_stb_o})
  ) else $error("decoder selected %b / %b", win_stb_o, def_stb_o);

endmodule

`default_nettype wire

/* hdl/wb_ram_window.sv */
// Word-wide on-chip RAM slave with byte selects and a one-cycle registered acknowledge
`timescale 1ns/10ps
`default_nettype none

module wb_ram_window #(
  parameter int RAM_AW = 9
) (
  input  logic                 clk,
  input  logic                 rst_lck,
  input  soc_bus_pkg::wb_req_t req_i,
  input  logic                 sel_stb_i,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  import soc_bus_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e            state;
  logic [DAT_W-1:0]  mem [2**RAM_AW];
  logic [DAT_W-1:0]  rd_dat;
  logic [RAM_AW-1:0] idx;
  logic              acc;

  assign idx = req_i.adr[RAM_AW-1:0];
  assign acc = sel_stb_i & req_i.cyc & req_i.stb & (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (acc) state <= ST_ACK;
        ST_ACK:  state <= ST_IDLE;  // Master drops stb after this edge
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Storage and read port
  always_ff @(posedge clk) begin
    if (acc) begin
      if (req_i.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
      rd_dat <= mem[idx];
    end
  end

  assign rsp_o.ack = (state == ST_ACK);
  assign rsp_o.dat = rsp_o.ack ? rd_dat : '0;  // Zero when idle, merged by OR

  a_ack_single: assert property (
    @(posedge clk) disable iff (!rst_lck)
    rsp_o.ack |=> !rsp_o.ack
  ) else $error("RAM ack held for two cycles");

endmodule

`default_nettype wire

/* hdl/wb_resp_merge.sv */
// Response merger: ORs RAM answers, default slave ack and interrupt acknowledge vector
`timescale 1ns/10ps
`default_nettype none

module wb_resp_merge #(
  parameter int NUM_RAM = 2
) (
  input  logic                 clk,
  input  logic                 rst_lck,
  input  soc_bus_pkg::wb_req_t req_i,
  input  logic                 def_stb_i,
  input  soc_bus_pkg::wb_rsp_t ram_rsp_i [NUM_RAM],
  input  logic [2:0]           iid_i,
  output logic                 inta_done_o,
  output soc_bus_pkg::wb_rsp_t rsp_o
);

  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic               def_ack;
  logic               def_inta;  // Current default ack belongs to an inta read
  logic [NUM_RAM-1:0] ram_ack;
  logic [DAT_W-1:0]   ram_dat;
  logic [DAT_W-1:0]   def_dat;

  always_comb begin
    ram_ack = '0;
    ram_dat = '0;
    for (int i = 0; i < NUM_RAM; i++) begin
      ram_ack[i] = ram_rsp_i[i].ack;
      ram_dat    = ram_dat | ram_rsp_i[i].dat;
    end
  end

  // Default slave, one ack per strobe
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      def_ack  <= 1'b0;
      def_inta <= 1'b0;
    end else begin
      def_ack  <= def_stb_i & !def_ack;
      def_inta <= def_stb_i & !def_ack & req_i.tgc & !req_i.we;
    end
  end

  // Vector follows the live id, the same value the controller clears
  assign def_dat     = def_inta ? {INTA_PREFIX, iid_i} : DEFAULT_DATA;
  assign rsp_o.dat   = ram_dat | (def_ack ? def_dat : '0);
  assign rsp_o.ack   = (|ram_ack) | def_ack;
  assign inta_done_o = def_ack & def_inta;

  a_single_slave: assert property (
    @(posedge clk) disable iff (!rst_lck)
    $onehot0({ram_ack, def_ack})
  ) else $error("two slaves acknowledged together: %b", {ram_ack, def_ack});

endmodule

`default_nettype wire

/* hdl/irq_ctrl.sv */
// Interrupt controller with edge detect on 8 lines, pending latch, fixed priority and ack clear
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl (
  input  logic       clk,
  input  logic       rst_lck,
  input  logic [7:0] irq_i,
  input  logic       inta_done_i,
  output logic       intr_o,
  output logic [2:0] iid_o
);

  logic [7:0] irq_q;     // Previous line levels
  logic [7:0] rise;
  logic [7:0] pending;
  logic [7:0] clr_mask;

  assign rise = irq_i & ~irq_q;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_q   <= '0;
      pending <= '0;
    end else begin
      irq_q   <= irq_i;
      // A new edge on the line being acknowledged stays pending
      pending <= (pending & ~clr_mask) | rise;
    end
  end

  // Lowest index has the highest priority
  always_comb begin
    iid_o = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pending[i]) iid_o = 3'(i);
    end
  end

  // Acknowledged line is the one whose id went out on the bus
  always_comb begin
    clr_mask = '0;
    if (inta_done_i) clr_mask[iid_o] = 1'b1;
  end

  assign intr_o = |pending;

endmodule

`default_nettype wire

/* hdl/soc_bus_top.sv */
// Bus fabric top: address decoder, RAM windows, response merger and interrupt controller
`timescale 1ns/10ps
`default_nettype none

module soc_bus_top #(
  parameter int NUM_RAM = 2,
  parameter int RAM_AW  = 9
) (
  input  logic                 clk,
  input  logic                 rst_lck,
  input  soc_bus_pkg::wb_req_t bus_req_i,
  output soc_bus_pkg::wb_rsp_t bus_rsp_o,
  input  logic [7:0]           irq_i,
  output logic                 intr_o
);

  import soc_bus_pkg::*;

  logic [NUM_RAM-1:0] win_stb;
  logic               def_stb;
  wb_rsp_t            ram_rsp [NUM_RAM];
  logic [2:0]         iid;
  logic               inta_done;

  wb_addr_decoder #(
    .NUM_RAM (NUM_RAM)
  ) wb_addr_decoder_inst (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .req_i     (bus_req_i),
    .win_stb_o (win_stb),
    .def_stb_o (def_stb)
  );

  // Base RAM is window 0, text memory window 1
  for (genvar i = 0; i < NUM_RAM; i++) begin : g_ram
    wb_ram_window #(
      .RAM_AW (RAM_AW)
    ) wb_ram_window_inst (
      .clk       (clk),
      .rst_lck   (rst_lck),
      .req_i     (bus_req_i),  // Shared request, private strobe
      .sel_stb_i (win_stb[i]),
      .rsp_o     (ram_rsp[i])
    );
  end

  wb_resp_merge #(
    .NUM_RAM (NUM_RAM)
  ) wb_resp_merge_inst (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .req_i       (bus_req_i),
    .def_stb_i   (def_stb),
    .ram_rsp_i   (ram_rsp),
    .iid_i       (iid),
    .inta_done_o (inta_done),
    .rsp_o       (bus_rsp_o)
  );

  irq_ctrl irq_ctrl_inst (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .irq_i       (irq_i),
    .inta_done_i (inta_done),
    .intr_o      (intr_o),
    .iid_o       (iid)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// Testbench clock and reset source: 10 ns clock, reset low for 8 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_lck
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_lck = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_lck = 1'b1;  // Released just after the edge, like other inputs
  end

endmodule

`default_nettype wire

/* bench/soc_bus_tb.sv */
// Bus fabric testbench with Wishbone driver, LCG, RAM model, directed tests and report
`timescale 1ns/10ps
`default_nettype none

module soc_bus_tb;

  import soc_bus_pkg::*;

  localparam logic [12:0] VEC_PREFIX = 13'h0001;   // Upper bits of every vector
  localparam logic [18:0] TEXT_BASE  = 19'h5c000;  // Byte address 0xb8000

  logic        clk;
  logic        rst_lck;
  wb_req_t     bus_req;
  wb_rsp_t     bus_rsp;
  logic [7:0]  irq;
  logic        intr;
  logic [31:0] lcg_state;
  logic [15:0] model [2][512];  // Expected RAM contents per window
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;

  tb_clock_gen tb_clock_gen_inst (
    .clk     (clk),
    .rst_lck (rst_lck)
  );

  soc_bus_top #(
    .NUM_RAM (2),
    .RAM_AW  (9)
  ) soc_bus_top_inst (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .irq_i     (irq),
    .intr_o    (intr)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand_word(output logic [15:0] w);
    lcg_state = lcg_next(lcg_state);
    w = lcg_state[31:16];  // Upper bits are the better ones
  endtask

  // Word address of an entry inside RAM window w
  function automatic logic [18:0] win_adr(input int w, input logic [8:0] idx);
    return (w == 1 ? TEXT_BASE : 19'h0) | {10'd0, idx};
  endfunction

  // Bytes with their select bit set take the new value
  function automatic logic [15:0] apply_sel(input logic [15:0] old_w, input logic [15:0] new_w,
                                            input logic [1:0] sel);
    logic [15:0] r;
    r = old_w;
    if (sel[0]) r[7:0] = new_w[7:0];
    if (sel[1]) r[15:8] = new_w[15:8];
    return r;
  endfunction

  task automatic check_eq(input string what, input logic [15:0] got, input logic [15:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("[FAIL] %0t: %s returned %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    test_cnt++;
    $display("Test %s finished with %0d errors", name, err_cnt - err0);
  endtask

  // One classic cycle with ack sampled at the falling edge
  task automatic bus_access(input logic [18:0] adr, input bus_space_e space, input logic we,
                            input logic [15:0] wdat, input logic [1:0] sel, input logic tgc,
                            output logic [15:0] rdat);
    int   edges;
    logic got;
    edges = 0;
    got   = 1'b0;
    rdat  = '0;
    @(posedge clk);
    #1;
    bus_req = '{adr: adr, space: space, dat: wdat, sel: sel, we: we,
                cyc: 1'b1, stb: 1'b1, tgc: tgc};
    while (!got && edges < 20) begin
      @(negedge clk);
      if (bus_rsp.ack) begin
        got  = 1'b1;
        rdat = bus_rsp.dat;
      end
      @(posedge clk);
      edges++;
    end
    #1;
    bus_req = '0;  // Drop cyc and stb after the ack edge
    if (!got) begin
      $display("Access to address %h got no ack within 20 cycles", adr);
      err_cnt++;
    end else begin
      check_cnt++;
      assert (edges == 2) else begin
        $display("[FAIL] %0t: ack after %0d edges, expected 2", $time, edges);
        err_cnt++;
      end
    end
  endtask

  task automatic reset_values();
    int n;
    int err0;
    err0 = err_cnt;
    n    = 0;
    while (rst_lck !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst_lck !== 1'b1) begin
      $display("Reset was never released");
      err_cnt++;
    end
    @(negedge clk);
    check_eq("ack after reset", {15'd0, bus_rsp.ack}, 16'd0);
    check_eq("intr after reset", {15'd0, intr}, 16'd0);
    report_test("reset", err0);
  endtask

  // Same index in both windows with different data catches aliasing
  task automatic ram_readback();
    logic [15:0] d;
    logic [15:0] rd;
    logic [8:0]  idx;
    int          err0;
    err0 = err_cnt;
    for (int i = 0; i < 8; i++) begin
      idx = 9'(i * 37 + 3);
      for (int w = 0; w < 2; w++) begin
        rand_word(d);
        model[w][idx] = d;
        bus_access(win_adr(w, idx), SPACE_MEM, 1'b1, d, 2'b11, 1'b0, rd);
      end
    end
    for (int i = 0; i < 8; i++) begin
      idx = 9'(i * 37 + 3);
      for (int w = 0; w < 2; w++) begin
        bus_access(win_adr(w, idx), SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b0, rd);
        check_eq($sformatf("window %0d word %h", w, idx), rd, model[w][idx]);
      end
    end
    report_test("ram windows", err0);
  endtask

  task automatic byte_select_writes();
    logic [15:0] d;
    logic [15:0] rd;
    logic [8:0]  idx;
    int          err0;
    err0 = err_cnt;
    idx  = 9'h1a5;
    rand_word(d);
    model[0][idx] = d;
    bus_access(win_adr(0, idx), SPACE_MEM, 1'b1, d, 2'b11, 1'b0, rd);
    for (int s = 0; s < 4; s++) begin
      rand_word(d);
      model[0][idx] = apply_sel(model[0][idx], d, 2'(s));
      bus_access(win_adr(0, idx), SPACE_MEM, 1'b1, d, 2'(s), 1'b0, rd);
      bus_access(win_adr(0, idx), SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b0, rd);
      check_eq($sformatf("write with sel %b", 2'(s)), rd, model[0][idx]);
    end
    report_test("byte selects", err0);
  endtask

  task automatic default_slave_access();
    logic [15:0] rd;
    int          err0;
    err0 = err_cnt;
    bus_access(19'h40000, SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b0, rd);
    check_eq("unmapped memory read", rd, 16'hffff);
    bus_access(19'h00003, SPACE_IO, 1'b0, 16'h0, 2'b11, 1'b0, rd);
    check_eq("I/O read below base RAM", rd, 16'hffff);
    bus_access(TEXT_BASE | 19'h3, SPACE_IO, 1'b0, 16'h0, 2'b11, 1'b0, rd);
    check_eq("I/O read at text window", rd, 16'hffff);
    // These writes must not reach either RAM
    bus_access(19'h40003, SPACE_MEM, 1'b1, 16'h1234, 2'b11, 1'b0, rd);
    bus_access(19'h00003, SPACE_IO, 1'b1, 16'h5678, 2'b11, 1'b0, rd);
    bus_access(TEXT_BASE | 19'h3, SPACE_IO, 1'b1, 16'h9abc, 2'b11, 1'b0, rd);
    bus_access(win_adr(0, 9'h3), SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b0, rd);
    check_eq("base RAM after default writes", rd, model[0][9'h3]);
    bus_access(win_adr(1, 9'h3), SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b0, rd);
    check_eq("text RAM after default writes", rd, model[1][9'h3]);
    report_test("default slave", err0);
  endtask

  task automatic irq_acknowledge();
    logic [15:0] rd;
    int          n;
    int          err0;
    err0 = err_cnt;
    @(posedge clk);
    #1;
    irq = 8'b0010_0100;  // Lines 5 and 2
    n   = 0;
    @(negedge clk);
    while (!intr && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!intr) begin
      $display("intr_o did not rise within 10 cycles after irq 2 and 5");
      err_cnt++;
    end
    bus_access(19'h0, SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b1, rd);
    check_eq("first acknowledge vector", rd, {VEC_PREFIX, 3'd2});
    bus_access(19'h0, SPACE_MEM, 1'b0, 16'h0, 2'b11, 1'b1, rd);
    check_eq("second acknowledge vector", rd, {VEC_PREFIX, 3'd5});
    @(negedge clk);
    check_eq("intr after both acknowledges", {15'd0, intr}, 16'd0);
    @(posedge clk);
    #1;
    irq = '0;
    report_test("interrupts", err0);
  endtask

  initial begin
    bus_req   = '0;
    irq       = '0;
    lcg_state = 32'hdc8a;
    err_cnt   = 0;
    check_cnt = 0;
    test_cnt  = 0;
    reset_values();
    ram_readback();
    byte_select_writes();
    default_slave_access();
    irq_acknowledge();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/wb_addr_decoder.sv
hdl/wb_ram_window.sv
hdl/wb_resp_merge.sv
hdl/irq_ctrl.sv
hdl/soc_bus_top.sv
bench/tb_clock_gen.sv
bench/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the bus fabric testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module soc_bus_tb -f filelist.f -o soc_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/soc_bus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
exit 0
